//--- logic/pc_io_pkg.sv
package pc_io_pkg;

   localparam int IO_ADDR_W        = 10;
   localparam int BYTE_W           = 8;
   localparam int AXI_ADDR_W       = 12;
   localparam int AXI_DATA_W       = 32;
   localparam int CYCLE_FIFO_DEPTH = 4;
   localparam int CYCLE_PTR_W      = $clog2(CYCLE_FIFO_DEPTH);
   localparam int PAGE_W           = 4;

   localparam logic [BYTE_W-1:0] UNCLAIMED_DATA = 8'hFF;  // Open bus value
   localparam logic [1:0]        AXI_RESP_OKAY  = 2'b00;

   // Port groups of 32 ports each, from port bits 7:5
   typedef enum logic [2:0] {
      GRP_DMA      = 3'd0,  // 0x000
      GRP_PIC      = 3'd1,  // 0x020
      GRP_TIMER    = 3'd2,  // 0x040
      GRP_PPI      = 3'd3,  // 0x060
      GRP_DMA_PAGE = 3'd4,  // 0x080
      GRP_NMI_MASK = 3'd5,  // 0x0A0
      GRP_UNUSED_6 = 3'd6,
      GRP_UNUSED_7 = 3'd7
   } io_group_e;

   typedef enum logic [2:0] {
      REG_PPI_A, REG_PPI_B, REG_PPI_C, REG_NMI_MASK, REG_PAGE, REG_NONE
   } board_reg_e;

   // PPI port B, bit 7 down to bit 0
   typedef struct packed {
      logic sw1_sel;      // Port A shows switch bank 1
      logic spare;
      logic ch_ck_dis;    // Clears and blocks channel check latch
      logic par_chk_dis;  // Clears and blocks parity latch
      logic motor_off;    // Cassette motor
      logic sw2_hi_sel;   // Upper switch bank 2 nibble on port C
      logic spkr_data;
      logic spkr_gate;
   } port_b_t;

   typedef struct packed {
      logic                 write;
      logic                 byte_en;
      logic [IO_ADDR_W-1:0] port;
      logic [BYTE_W-1:0]    data;
   } io_cycle_t;

   typedef struct packed {
      logic                  awvalid;
      logic [AXI_ADDR_W-1:0] awaddr;
      logic                  wvalid;
      logic [AXI_DATA_W-1:0] wdata;
      logic [3:0]            wstrb;
      logic                  bready;
      logic                  arvalid;
      logic [AXI_ADDR_W-1:0] araddr;
      logic                  rready;
   } axi_lite_req_t;

   typedef struct packed {
      logic                  awready;
      logic                  wready;
      logic                  arready;
      logic                  bvalid;
      logic [1:0]            bresp;
      logic                  rvalid;
      logic [AXI_DATA_W-1:0] rdata;
      logic [1:0]            rresp;
   } axi_lite_rsp_t;

endpackage

//--- logic/axi_request_capture.sv
`timescale 1ns/10ps

module axi_request_capture (
   input  logic                     clk,
   input  logic                     reset_n,
   input  pc_io_pkg::axi_lite_req_t axi_req_i,
   input  logic                     full_i,
   output logic                     awready_o,
   output logic                     wready_o,
   output logic                     arready_o,
   output logic                     push_o,
   output pc_io_pkg::io_cycle_t     cycle_o
);

   import pc_io_pkg::*;

   logic      wr_pair;
   logic      can_accept;
   logic      wr_accept;
   logic      rd_accept;
   io_cycle_t next_cycle;

   assign wr_pair = axi_req_i.awvalid && axi_req_i.wvalid;

   // full_i does not yet count a push still in flight, so hold off for it
   assign can_accept = !full_i && !push_o;

   assign wr_accept = wr_pair && can_accept;
   assign rd_accept = axi_req_i.arvalid && !wr_pair && can_accept;  // Write wins a tie

   assign awready_o = wr_accept;
   assign wready_o  = wr_accept;
   assign arready_o = rd_accept;

   // One port per 32-bit word, port byte in lane 0
   always_comb begin
      next_cycle = '0;
      if (wr_pair) begin
         next_cycle.write   = 1'b1;
         next_cycle.byte_en = axi_req_i.wstrb[0];
         next_cycle.port    = axi_req_i.awaddr[AXI_ADDR_W-1:2];
         next_cycle.data    = axi_req_i.wdata[BYTE_W-1:0];
      end else begin
         next_cycle.byte_en = 1'b1;
         next_cycle.port    = axi_req_i.araddr[AXI_ADDR_W-1:2];
      end
   end

   always_ff @(posedge clk) begin
      if (reset_n == 1'b0) begin
         push_o <= 1'b0;
      end else begin
         push_o <= wr_accept || rd_accept;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_accept || rd_accept) begin
         cycle_o <= next_cycle;
      end
   end

endmodule

//--- logic/io_cycle_fifo.sv
`timescale 1ns/10ps

module io_cycle_fifo (
   input  logic                 clk,
   input  logic                 reset_n,
   input  logic                 push_i,
   input  pc_io_pkg::io_cycle_t cycle_i,
   input  logic                 pop_i,
   output pc_io_pkg::io_cycle_t head_o,
   output logic                 full_o,
   output logic                 empty_o
);

   import pc_io_pkg::*;

   io_cycle_t              mem [CYCLE_FIFO_DEPTH];
   logic [CYCLE_PTR_W-1:0] wr_ptr;
   logic [CYCLE_PTR_W-1:0] rd_ptr;
   logic [CYCLE_PTR_W:0]   count;
   logic                   do_push;
   logic                   do_pop;

   assign full_o  = (count == (CYCLE_PTR_W+1)'(CYCLE_FIFO_DEPTH));
   assign empty_o = (count == '0);
   assign do_push = push_i && !full_o;
   assign do_pop  = pop_i && !empty_o;
   assign head_o  = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= cycle_i;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_n == 1'b0) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == CYCLE_PTR_W'(CYCLE_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == CYCLE_PTR_W'(CYCLE_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + do_push - do_pop;  // Both at once leaves it unchanged
      end
   end

endmodule

//--- logic/io_cycle_executor.sv
`timescale 1ns/10ps

module io_cycle_executor (
   input  logic                                  clk,
   input  logic                                  reset_n,
   input  pc_io_pkg::io_cycle_t                  head_i,
   input  logic                                  empty_i,
   input  logic                                  bready_i,
   input  logic                                  rready_i,
   input  logic [pc_io_pkg::BYTE_W-1:0]          rdata_i,
   output logic                                  pop_o,
   output logic                                  reg_wr_o,
   output pc_io_pkg::board_reg_e                 reg_sel_o,
   output logic [1:0]                            page_idx_o,
   output logic [pc_io_pkg::BYTE_W-1:0]          wdata_o,
   output logic                                  bvalid_o,
   output logic [1:0]                            bresp_o,
   output logic                                  rvalid_o,
   output logic [pc_io_pkg::AXI_DATA_W-1:0]      rdata_o,
   output logic [1:0]                            rresp_o
);

   import pc_io_pkg::*;

   io_group_e         group;
   logic              in_range;
   board_reg_e        sel;
   logic [BYTE_W-1:0] rd_byte;

   assign group    = io_group_e'(head_i.port[7:5]);
   assign in_range = (head_i.port[9:8] == 2'b00);  // Ports 0x100 and up have no decoder

   always_comb begin
      sel = REG_NONE;
      if (in_range) begin
         case (group)
            GRP_PPI: begin
               case (head_i.port[1:0])
                  2'd0:    sel = REG_PPI_A;
                  2'd1:    sel = REG_PPI_B;
                  2'd2:    sel = REG_PPI_C;
                  default: sel = REG_NONE;
               endcase
            end
            GRP_DMA_PAGE: sel = REG_PAGE;
            GRP_NMI_MASK: sel = REG_NMI_MASK;  // Mirrored over the whole group
            default:      sel = REG_NONE;      // DMA, PIC, timer have no device here
         endcase
      end
      if (head_i.write && !head_i.byte_en) begin
         sel = REG_NONE;
      end
   end

   // One response slot, refill only once it drains
   assign pop_o      = !empty_i && !bvalid_o && !rvalid_o;
   assign reg_wr_o   = pop_o && head_i.write;
   assign reg_sel_o  = sel;
   assign page_idx_o = head_i.port[1:0];
   assign wdata_o    = head_i.data;

   assign rd_byte = (sel == REG_NONE) ? UNCLAIMED_DATA : rdata_i;

   always_ff @(posedge clk) begin
      if (reset_n == 1'b0) begin
         bvalid_o <= 1'b0;
         rvalid_o <= 1'b0;
      end else begin
         if (bvalid_o && bready_i) begin
            bvalid_o <= 1'b0;
         end
         if (rvalid_o && rready_i) begin
            rvalid_o <= 1'b0;
         end
         if (pop_o) begin
            if (head_i.write) begin
               bvalid_o <= 1'b1;
            end else begin
               rvalid_o <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (pop_o && !head_i.write) begin
         rdata_o <= AXI_DATA_W'(rd_byte);  // Zero-extended from lane 0
      end
   end

   assign bresp_o = AXI_RESP_OKAY;
   assign rresp_o = AXI_RESP_OKAY;

endmodule

//--- logic/board_control_regs.sv
`timescale 1ns/10ps

module board_control_regs (
   input  logic                              clk,
   input  logic                              reset_n,
   input  logic                              reg_wr_i,
   input  pc_io_pkg::board_reg_e             reg_sel_i,
   input  logic [1:0]                        page_idx_i,
   input  logic [pc_io_pkg::BYTE_W-1:0]      wdata_i,
   input  logic [pc_io_pkg::BYTE_W-1:0]      sw1_i,
   input  logic [pc_io_pkg::BYTE_W-1:0]      sw2_i,
   input  logic                              par_err_i,
   input  logic                              io_ch_ck_i,
   input  logic [1:0]                        dma_chan_i,
   output logic [pc_io_pkg::BYTE_W-1:0]      rdata_o,
   output logic [pc_io_pkg::PAGE_W-1:0]      dma_page_o,
   output logic                              nmi_o,
   output logic                              spkr_gate_o,
   output logic                              spkr_data_o,
   output logic                              motor_off_o
);

   import pc_io_pkg::*;

   port_b_t     port_b;
   logic        nmi_mask;
   logic        par_latch;
   logic        ch_ck_latch;
   logic [3:0]  sw2_nibble;
   logic [PAGE_W-1:0] page_regs [4];  // One per DMA channel

   // CPU writes, A and C are input ports so their writes fall through
   always_ff @(posedge clk) begin
      if (reset_n == 1'b0) begin
         port_b   <= '0;
         nmi_mask <= 1'b0;
         for (int i = 0; i < 4; i++) begin
            page_regs[i] <= '0;
         end
      end else if (reg_wr_i) begin
         case (reg_sel_i)
            REG_PPI_B:    port_b <= port_b_t'(wdata_i);
            REG_NMI_MASK: nmi_mask <= wdata_i[7];
            REG_PAGE:     page_regs[page_idx_i] <= wdata_i[PAGE_W-1:0];
            default:      ;
         endcase
      end
   end

   // Error latches, held clear while their disable bit is set
   always_ff @(posedge clk) begin
      if (reset_n == 1'b0) begin
         par_latch   <= 1'b0;
         ch_ck_latch <= 1'b0;
      end else begin
         if (port_b.par_chk_dis) begin
            par_latch <= 1'b0;
         end else if (par_err_i) begin
            par_latch <= 1'b1;
         end

         if (port_b.ch_ck_dis) begin
            ch_ck_latch <= 1'b0;
         end else if (io_ch_ck_i) begin
            ch_ck_latch <= 1'b1;
         end
      end
   end

   assign nmi_o      = nmi_mask && (par_latch || ch_ck_latch);
   assign dma_page_o = page_regs[dma_chan_i];

   assign spkr_gate_o = port_b.spkr_gate;
   assign spkr_data_o = port_b.spkr_data;
   assign motor_off_o = port_b.motor_off;

   assign sw2_nibble = port_b.sw2_hi_sel ? sw2_i[7:4] : sw2_i[3:0];

   always_comb begin
      case (reg_sel_i)
         REG_PPI_A:    rdata_o = port_b.sw1_sel ? sw1_i : '0;  // No keyboard behind it
         REG_PPI_B:    rdata_o = port_b;
         REG_PPI_C:    rdata_o = {par_latch, ch_ck_latch, 2'b00, sw2_nibble};
         REG_NMI_MASK: rdata_o = {nmi_mask, 7'b0};
         default:      rdata_o = UNCLAIMED_DATA;  // Page registers are write-only
      endcase
   end

endmodule

//--- logic/pc_io_board.sv
`timescale 1ns/10ps

module pc_io_board (
   input  logic                              clk,
   input  logic                              reset_n,
   input  pc_io_pkg::axi_lite_req_t          axi_req_i,
   output pc_io_pkg::axi_lite_rsp_t          axi_rsp_o,
   input  logic [pc_io_pkg::BYTE_W-1:0]      sw1_i,
   input  logic [pc_io_pkg::BYTE_W-1:0]      sw2_i,
   input  logic                              par_err_i,
   input  logic                              io_ch_ck_i,
   input  logic [1:0]                        dma_chan_i,
   output logic [pc_io_pkg::PAGE_W-1:0]      dma_page_o,
   output logic                              nmi_o,
   output logic                              spkr_gate_o,
   output logic                              spkr_data_o,
   output logic                              motor_off_o
);

   import pc_io_pkg::*;

   logic              push;
   logic              full;
   logic              empty;
   logic              pop;
   io_cycle_t         push_cycle;
   io_cycle_t         head_cycle;
   logic              reg_wr;
   board_reg_e        reg_sel;
   logic [1:0]        page_idx;
   logic [BYTE_W-1:0] reg_wdata;
   logic [BYTE_W-1:0] reg_rdata;

   axi_request_capture i_axi_request_capture (
      .clk       (clk),
      .reset_n   (reset_n),
      .axi_req_i (axi_req_i),
      .full_i    (full),
      .awready_o (axi_rsp_o.awready),
      .wready_o  (axi_rsp_o.wready),
      .arready_o (axi_rsp_o.arready),
      .push_o    (push),
      .cycle_o   (push_cycle)
   );

   io_cycle_fifo i_io_cycle_fifo (
      .clk     (clk),
      .reset_n (reset_n),
      .push_i  (push),
      .cycle_i (push_cycle),
      .pop_i   (pop),
      .head_o  (head_cycle),
      .full_o  (full),
      .empty_o (empty)
   );

   io_cycle_executor i_io_cycle_executor (
      .clk        (clk),
      .reset_n    (reset_n),
      .head_i     (head_cycle),
      .empty_i    (empty),
      .bready_i   (axi_req_i.bready),
      .rready_i   (axi_req_i.rready),
      .rdata_i    (reg_rdata),
      .pop_o      (pop),
      .reg_wr_o   (reg_wr),
      .reg_sel_o  (reg_sel),
      .page_idx_o (page_idx),
      .wdata_o    (reg_wdata),
      .bvalid_o   (axi_rsp_o.bvalid),
      .bresp_o    (axi_rsp_o.bresp),
      .rvalid_o   (axi_rsp_o.rvalid),
      .rdata_o    (axi_rsp_o.rdata),
      .rresp_o    (axi_rsp_o.rresp)
   );

   board_control_regs i_board_control_regs (
      .clk         (clk),
      .reset_n     (reset_n),
      .reg_wr_i    (reg_wr),
      .reg_sel_i   (reg_sel),
      .page_idx_i  (page_idx),
      .wdata_i     (reg_wdata),
      .sw1_i       (sw1_i),
      .sw2_i       (sw2_i),
      .par_err_i   (par_err_i),
      .io_ch_ck_i  (io_ch_ck_i),
      .dma_chan_i  (dma_chan_i),
      .rdata_o     (reg_rdata),
      .dma_page_o  (dma_page_o),
      .nmi_o       (nmi_o),
      .spkr_gate_o (spkr_gate_o),
      .spkr_data_o (spkr_data_o),
      .motor_off_o (motor_off_o)
   );

endmodule

//--- tests/pc_io_board_tests.svh
task automatic pulse_error(input logic channel_check);
   @(posedge clk);
   #1;
   if (channel_check) begin
      io_ch_ck = 1'b1;
   end else begin
      par_err = 1'b1;
   end
   @(posedge clk);  // Latch samples here
   #1;
   io_ch_ck = 1'b0;
   par_err  = 1'b0;
endtask

task automatic check_pages(input string what);
   int ch;
   for (ch = 0; ch < 4; ch++) begin
      @(posedge clk);
      #1;
      dma_chan = 2'(ch);
      @(negedge clk);
      check_value(what, dma_page, page_model[ch]);
   end
endtask

task automatic test_reset_port_b();
   logic [BYTE_W-1:0] value;
   expect_read(10'h061, 8'h00, "port B after reset");
   expect_read(10'h0A0, 8'h00, "NMI mask after reset");
   check_value("board outputs after reset", {spkr_gate, spkr_data, motor_off, nmi, dma_page}, 0);
   repeat (8) begin
      value = 8'($random(seed));
      write_port(10'h061, value);
      expect_read(10'h061, value, "port B readback");
      check_value("speaker gate", spkr_gate, value[0]);
      check_value("speaker data", spkr_data, value[1]);
      check_value("motor off", motor_off, value[3]);
   end
endtask

task automatic test_switch_readback();
   logic [BYTE_W-1:0] ctrl;
   logic [3:0]        nibble;
   repeat (8) begin
      ctrl = 8'($random(seed));
      @(posedge clk);
      #1;
      sw1 = 8'($random(seed));
      sw2 = 8'($random(seed));
      write_port(10'h061, ctrl);
      expect_read(10'h060, ctrl[7] ? sw1 : 8'h00, "port A switch bank 1");
      nibble = ctrl[2] ? sw2[7:4] : sw2[3:0];
      expect_read(10'h062, {4'h0, nibble}, "port C switch bank 2");
   end
endtask

task automatic test_parity_nmi();
   logic [BYTE_W-1:0] mask;
   mask = 8'h00;
   write_port(10'h061, 8'h00);  // Both checks enabled, low sw2 nibble
   write_port(10'h0A0, 8'h00);
   pulse_error(1'b0);
   expect_read(10'h062, {4'b1000, sw2[3:0]}, "parity latch set");
   check_value("NMI while masked", nmi, 1'b0);
   repeat (4) begin
      mask = {~mask[7], 7'($random(seed))};  // Mask bit flips every pass
      write_port(10'h0A0, mask);
      check_value("NMI follows mask", nmi, mask[7]);
      expect_read(10'h0A7, {mask[7], 7'h00}, "NMI mask mirror");
   end
   write_port(10'h0A0, 8'h80);
   write_port(10'h061, 8'h10);  // Parity check off
   expect_read(10'h062, {4'h0, sw2[3:0]}, "parity latch cleared");
   check_value("NMI after parity clear", nmi, 1'b0);
   pulse_error(1'b0);
   expect_read(10'h062, {4'h0, sw2[3:0]}, "parity latch blocked");

   write_port(10'h061, 8'h00);
   pulse_error(1'b1);
   expect_read(10'h062, {4'b0100, sw2[3:0]}, "channel check latch set");
   check_value("NMI from channel check", nmi, 1'b1);
   write_port(10'h061, 8'h20);  // Channel check off
   expect_read(10'h062, {4'h0, sw2[3:0]}, "channel check latch cleared");
   check_value("NMI after channel check clear", nmi, 1'b0);
   pulse_error(1'b1);
   expect_read(10'h062, {4'h0, sw2[3:0]}, "channel check latch blocked");
   write_port(10'h061, 8'h00);
   write_port(10'h0A0, 8'h00);
endtask

task automatic test_dma_pages();
   logic [BYTE_W-1:0] value;
   int i;
   for (i = 0; i < 4; i++) begin
      value = 8'($random(seed));
      page_model[i] = value[PAGE_W-1:0];  // High nibble is dropped
      write_port(10'h080 + 10'(i), value);
   end
   for (i = 0; i < 4; i++) begin
      expect_read(10'h080 + 10'(i), 8'hFF, "page register read");
   end
   check_pages("DMA page");
endtask

task automatic test_unclaimed();
   logic [IO_ADDR_W-1:0] ports [10];
   logic [BYTE_W-1:0]    ctrl;
   int i;
   ports = '{10'h000, 10'h021, 10'h043, 10'h063, 10'h0C0,
             10'h0FF, 10'h100, 10'h161, 10'h181, 10'h3FF};
   ctrl = 8'($random(seed));
   write_port(10'h061, ctrl);
   write_port(10'h0A0, 8'h80);
   for (i = 0; i < 10; i++) begin
      expect_read(ports[i], UNCLAIMED_DATA, "unclaimed port read");
      write_port(ports[i], 8'($random(seed)));
   end
   expect_read(10'h061, ctrl, "port B after unclaimed writes");
   expect_read(10'h0A0, 8'h80, "NMI mask after unclaimed writes");
   check_pages("DMA page after unclaimed writes");
   write_port(10'h061, ~ctrl, 4'b1110);  // Lane 0 strobe clear
   expect_read(10'h061, ctrl, "port B after write without byte enable");
   write_port(10'h0A0, 8'h00);
endtask

task automatic test_back_pressure();
   logic [BYTE_W-1:0] values [6];
   logic              accept;
   int                sent;
   int                responses;
   int                idle;
   int                i;
   for (i = 0; i < 6; i++) begin
      values[i] = 8'($random(seed));
   end
   sent      = 0;
   responses = 0;
   idle      = 0;
   @(posedge clk);
   #1;
   axi_req.bready = 1'b0;
   drive_write_channel(10'h061, values[0], 4'hF);
   while (responses < 6) begin
      @(negedge clk);
      accept = axi_rsp.awready;
      if (axi_rsp.bvalid && axi_req.bready) begin
         responses++;
      end
      idle = accept ? 0 : idle + 1;
      @(posedge clk);
      #1;
      if (accept) begin
         sent++;
         if (sent < 6) begin
            drive_write_channel((sent % 2 == 0) ? 10'h061 : 10'h0A0, values[sent], 4'hF);
         end else begin
            axi_req.awvalid = 1'b0;
            axi_req.wvalid  = 1'b0;
         end
      end
      if (!axi_req.bready && idle == 16) begin  // Queue and slot are full
         check_value("at most five writes accepted with B ready low", sent <= 5, 1'b1);
         axi_req.bready = 1'b1;
      end
   end
   axi_req.bready = 1'b0;
   expect_read(10'h061, values[4], "port B after back-pressure");
   expect_read(10'h0A0, {values[5][7], 7'h00}, "NMI mask after back-pressure");
   check_value("speaker gate after back-pressure", spkr_gate, values[4][0]);
endtask

//--- tests/pc_io_board_tb.sv
`timescale 1ns/10ps

module pc_io_board_tb;

   import pc_io_pkg::*;

   localparam int CLK_PERIOD       = 4;
   localparam int NUM_TESTS        = 6;
   localparam int MAX_TRANSACTIONS = 200;  // Upper bound per test
   localparam int CYCLES_PER_TRANS = 20;
   localparam int WATCHDOG_NS      = NUM_TESTS * MAX_TRANSACTIONS * CYCLES_PER_TRANS * CLK_PERIOD;

   logic              clk;
   logic              reset_n;
   axi_lite_req_t     axi_req;
   axi_lite_rsp_t     axi_rsp;
   logic [BYTE_W-1:0] sw1;
   logic [BYTE_W-1:0] sw2;
   logic              par_err;
   logic              io_ch_ck;
   logic [1:0]        dma_chan;
   logic [PAGE_W-1:0] dma_page;
   logic              nmi;
   logic              spkr_gate;
   logic              spkr_data;
   logic              motor_off;

   int                seed   = 31098;
   int                errors = 0;
   int                checks = 0;
   logic [PAGE_W-1:0] page_model [4];  // Last nibble written per DMA channel

   pc_io_board i_pc_io_board (
      .clk         (clk),
      .reset_n     (reset_n),
      .axi_req_i   (axi_req),
      .axi_rsp_o   (axi_rsp),
      .sw1_i       (sw1),
      .sw2_i       (sw2),
      .par_err_i   (par_err),
      .io_ch_ck_i  (io_ch_ck),
      .dma_chan_i  (dma_chan),
      .dma_page_o  (dma_page),
      .nmi_o       (nmi),
      .spkr_gate_o (spkr_gate),
      .spkr_data_o (spkr_data),
      .motor_off_o (motor_off)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("FAIL %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      end
   endtask

   // Ready low on about one cycle in four
   function automatic logic ready_with_stall();
      return ($random(seed) & 3) != 0;
   endfunction

   task automatic drive_write_channel(input logic [IO_ADDR_W-1:0] port,
                                      input logic [BYTE_W-1:0] data, input logic [3:0] strb);
      axi_req.awvalid = 1'b1;
      axi_req.awaddr  = {port, 2'b00};  // One port per word
      axi_req.wvalid  = 1'b1;
      axi_req.wdata   = {24'h0, data};
      axi_req.wstrb   = strb;
   endtask

   task automatic write_port(input logic [IO_ADDR_W-1:0] port, input logic [BYTE_W-1:0] data,
                             input logic [3:0] strb = 4'hF);
      @(posedge clk);
      #1;
      drive_write_channel(port, data, strb);
      @(negedge clk);
      while (!axi_rsp.awready) begin
         @(negedge clk);
      end
      check_value("W ready with AW ready", axi_rsp.wready, 1'b1);
      @(posedge clk);  // Acceptance edge
      #1;
      axi_req.awvalid = 1'b0;
      axi_req.wvalid  = 1'b0;
      axi_req.bready  = ready_with_stall();
      @(negedge clk);
      while (!(axi_rsp.bvalid && axi_req.bready)) begin
         @(posedge clk);
         #1;
         axi_req.bready = ready_with_stall();
         @(negedge clk);
      end
      check_value("write response", axi_rsp.bresp, AXI_RESP_OKAY);
      @(posedge clk);
      #1;
      axi_req.bready = 1'b0;
   endtask

   task automatic read_port(input logic [IO_ADDR_W-1:0] port, output logic [BYTE_W-1:0] data);
      @(posedge clk);
      #1;
      axi_req.arvalid = 1'b1;
      axi_req.araddr  = {port, 2'b00};
      @(negedge clk);
      while (!axi_rsp.arready) begin
         @(negedge clk);
      end
      @(posedge clk);
      #1;
      axi_req.arvalid = 1'b0;
      axi_req.rready  = ready_with_stall();
      @(negedge clk);
      while (!(axi_rsp.rvalid && axi_req.rready)) begin
         @(posedge clk);
         #1;
         axi_req.rready = ready_with_stall();
         @(negedge clk);
      end
      data = axi_rsp.rdata[BYTE_W-1:0];
      check_value("read data upper lanes", axi_rsp.rdata[AXI_DATA_W-1:BYTE_W], 0);
      check_value("read response", axi_rsp.rresp, AXI_RESP_OKAY);
      @(posedge clk);
      #1;
      axi_req.rready = 1'b0;
   endtask

   task automatic expect_read(input logic [IO_ADDR_W-1:0] port, input logic [BYTE_W-1:0] exp,
                              input string what);
      logic [BYTE_W-1:0] got;
      read_port(port, got);
      check_value(what, got, exp);
   endtask

   `include "pc_io_board_tests.svh"

   initial begin
      clk      = 1'b0;
      reset_n  = 1'b0;
      axi_req  = '0;
      sw1      = '0;
      sw2      = '0;
      par_err  = 1'b0;
      io_ch_ck = 1'b0;
      dma_chan = '0;
      repeat (4) @(posedge clk);
      #1;
      reset_n = 1'b1;
      @(negedge clk);
      check_value("ready and valid flags after reset",
                  {axi_rsp.awready, axi_rsp.wready, axi_rsp.arready,
                   axi_rsp.bvalid, axi_rsp.rvalid}, 0);

      test_reset_port_b();
      test_switch_readback();
      test_parity_nmi();
      test_dma_pages();
      test_unclaimed();
      test_back_pressure();

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

//--- src.f
+incdir+tests
logic/pc_io_pkg.sv
logic/axi_request_capture.sv
logic/io_cycle_fifo.sv
logic/io_cycle_executor.sv
logic/board_control_regs.sv
logic/pc_io_board.sv
tests/pc_io_board_tb.sv

//--- Makefile
TOP  := pc_io_board_tb
SRCS := $(wildcard logic/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)

.PHONY: all run clean

all: obj_dir/V$(TOP)

obj_dir/V$(TOP): src.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
